/* ram_selftest_pkg.sv */
`include "ram_selftest_settings.svh"

package ram_selftest_pkg;

    typedef logic [`RT_ADDR_WIDTH-1:0] rt_addr_t;

    typedef logic [`RT_DATA_WIDTH-1:0] rt_data_t;

    // Order matters, a pass runs them in this sequence
    typedef enum logic [1:0] {
        pat_address     = 2'd0,
        pat_inv_address = 2'd1,
        pat_checker     = 2'd2,
        pat_inv_checker = 2'd3
    } rt_pattern_t;

    typedef logic [7:0] rt_byte_t;

endpackage

/* ram_selftest_settings.svh */
`ifndef RAM_SELFTEST_SETTINGS_SVH
`define RAM_SELFTEST_SETTINGS_SVH

// Memory geometry
`define RT_ADDR_WIDTH 10
`define RT_DATA_WIDTH 16
`define RT_DEPTH 1024

// Patterns run in one pass
`define RT_NUM_PATTERNS 4

// Clocks per UART bit
`define RT_BAUD_DIV 16

`endif

/* ram_selftest_top.sv */
`timescale 1ns/10ps

module ram_selftest_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    output logic                          tx,
    output logic                          busy,
    output ram_selftest_pkg::rt_pattern_t pattern_index,
    output logic                          reading
);

    logic                          wr_en;
    logic                          rd_en;
    ram_selftest_pkg::rt_addr_t    wr_addr;
    ram_selftest_pkg::rt_addr_t    rd_addr;
    ram_selftest_pkg::rt_addr_t    rd_addr_q;
    ram_selftest_pkg::rt_data_t    wr_data;
    ram_selftest_pkg::rt_data_t    rd_data;
    ram_selftest_pkg::rt_data_t    expected;

    logic                          result_valid;
    logic                          result_error;
    logic                          result_accepted;
    ram_selftest_pkg::rt_pattern_t result_pattern;
    ram_selftest_pkg::rt_addr_t    result_addr;
    ram_selftest_pkg::rt_data_t    result_expected;
    ram_selftest_pkg::rt_data_t    result_actual;
    logic [7:0]                    pass_count;
    logic                          report_done;

    ram_selftest_pkg::rt_byte_t    tx_data;
    logic                          tx_data_ready;
    logic                          tx_data_accepted;
    logic                          tx_idle;

    ram_test_ctrl i_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .busy            (busy),
        .reading         (reading),
        .pattern         (pattern_index),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .rd_addr_q       (rd_addr_q),
        .rd_data         (rd_data),
        .expected        (expected),
        .result_valid    (result_valid),
        .result_error    (result_error),
        .result_pattern  (result_pattern),
        .result_addr     (result_addr),
        .result_expected (result_expected),
        .result_actual   (result_actual),
        .pass_count      (pass_count),
        .result_accepted (result_accepted),
        .report_done     (report_done)
    );

    sdp_ram i_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    test_pattern_gen i_wr_gen (
        .pattern (pattern_index),
        .addr    (wr_addr),
        .word    (wr_data)
    );

    // Follows the RAM read latency
    test_pattern_gen i_chk_gen (
        .pattern (pattern_index),
        .addr    (rd_addr_q),
        .word    (expected)
    );

    report_formatter i_fmt (
        .clk              (clk),
        .rst_n            (rst_n),
        .result_valid     (result_valid),
        .result_error     (result_error),
        .result_pattern   (result_pattern),
        .result_addr      (result_addr),
        .result_expected  (result_expected),
        .result_actual    (result_actual),
        .pass_count       (pass_count),
        .result_accepted  (result_accepted),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted),
        .tx_idle          (tx_idle),
        .report_done      (report_done)
    );

    uart_tx i_uart (
        .clk              (clk),
        .rst_n            (rst_n),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted),
        .tx_idle          (tx_idle),
        .tx               (tx)
    );

endmodule

/* ram_test_ctrl.sv */
`timescale 1ns/10ps
`include "ram_selftest_settings.svh"

module ram_test_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    output logic                          busy,
    output logic                          reading,
    output ram_selftest_pkg::rt_pattern_t pattern,
    output logic                          wr_en,
    output ram_selftest_pkg::rt_addr_t    wr_addr,
    output logic                          rd_en,
    output ram_selftest_pkg::rt_addr_t    rd_addr,
    output ram_selftest_pkg::rt_addr_t    rd_addr_q,
    input  ram_selftest_pkg::rt_data_t    rd_data,
    input  ram_selftest_pkg::rt_data_t    expected,
    output logic                          result_valid,
    output logic                          result_error,
    output ram_selftest_pkg::rt_pattern_t result_pattern,
    output ram_selftest_pkg::rt_addr_t    result_addr,
    output ram_selftest_pkg::rt_data_t    result_expected,
    output ram_selftest_pkg::rt_data_t    result_actual,
    output logic [7:0]                    pass_count,
    input  logic                          result_accepted,
    input  logic                          report_done
);

    localparam ram_selftest_pkg::rt_addr_t last_addr =
        ram_selftest_pkg::rt_addr_t'(`RT_DEPTH - 1);
    localparam ram_selftest_pkg::rt_pattern_t last_pattern =
        ram_selftest_pkg::rt_pattern_t'(`RT_NUM_PATTERNS - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_read,
        st_result,
        st_wait_report
    } state_t;

    state_t                     state;
    ram_selftest_pkg::rt_addr_t addr_cnt;
    logic                       rd_issued_all;
    logic                       cmp_valid;

    assign busy         = (state != st_idle);
    assign reading      = (state == st_read);
    assign wr_en        = (state == st_write);
    assign wr_addr      = addr_cnt;
    assign rd_en        = (state == st_read) && !rd_issued_all;
    assign rd_addr      = addr_cnt;
    assign result_valid = (state == st_result);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            addr_cnt      <= '0;
            rd_issued_all <= 1'b0;
            cmp_valid     <= 1'b0;
            pattern       <= ram_selftest_pkg::pat_address;
            pass_count    <= '0;
        end else begin
            // Word for rd_addr_q arrives from the RAM this cycle
            cmp_valid <= rd_en;
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_write;
                        addr_cnt <= '0;
                        pattern  <= ram_selftest_pkg::pat_address;
                    end
                end
                st_write: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    if (addr_cnt == last_addr) begin
                        state         <= st_read;
                        addr_cnt      <= '0;
                        rd_issued_all <= 1'b0;
                    end
                end
                st_read: begin
                    if (rd_en) begin
                        addr_cnt <= addr_cnt + 1'b1;
                        if (addr_cnt == last_addr) begin
                            rd_issued_all <= 1'b1;
                        end
                    end
                    if (cmp_valid) begin
                        if (rd_data != expected) begin
                            state <= st_result;
                        end else if (rd_addr_q == last_addr) begin
                            if (pattern == last_pattern) begin
                                pass_count <= pass_count + 1'b1;
                                state      <= st_result;
                            end else begin
                                pattern  <= ram_selftest_pkg::rt_pattern_t'(pattern + 1'b1);
                                addr_cnt <= '0;
                                state    <= st_write;
                            end
                        end
                    end
                end
                st_result: begin
                    if (result_accepted) begin
                        state <= st_wait_report;
                    end
                end
                default: begin
                    // Held until the record has left the UART
                    if (report_done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Result fields, captured when the pass ends
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        if (state == st_read && cmp_valid) begin
            result_pattern  <= pattern;
            result_addr     <= rd_addr_q;
            result_expected <= expected;
            result_actual   <= rd_data;
            result_error    <= (rd_data != expected);
        end
    end

    // A pass result only after the last word of the last pattern
    a_pass_after_last_word : assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid && !result_error |->
            (result_pattern == last_pattern) && (result_addr == last_addr)
    );

    a_result_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid && !result_accepted |=>
            $stable(result_error) && $stable(result_pattern) && $stable(result_addr) &&
            $stable(result_expected) && $stable(result_actual) && $stable(pass_count)
    );

endmodule

/* report_formatter.sv */
`timescale 1ns/10ps

module report_formatter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          result_valid,
    input  logic                          result_error,
    input  ram_selftest_pkg::rt_pattern_t result_pattern,
    input  ram_selftest_pkg::rt_addr_t    result_addr,
    input  ram_selftest_pkg::rt_data_t    result_expected,
    input  ram_selftest_pkg::rt_data_t    result_actual,
    input  logic [7:0]                    pass_count,
    output logic                          result_accepted,
    output ram_selftest_pkg::rt_byte_t    tx_data,
    output logic                          tx_data_ready,
    input  logic                          tx_data_accepted,
    input  logic                          tx_idle,
    output logic                          report_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_drain
    } state_t;

    state_t                     state;
    logic [2:0]                 byte_idx;
    logic [2:0]                 last_idx;
    logic [15:0]                addr_ext;
    ram_selftest_pkg::rt_byte_t rec [8];

    assign addr_ext        = 16'(result_addr);
    assign result_accepted = (state == st_idle) && result_valid;
    assign tx_data         = rec[byte_idx];
    assign tx_data_ready   = (state == st_send);
    assign report_done     = (state == st_drain) && tx_idle;

    // Pass record uses only the first two bytes
    always_ff @(posedge clk) begin
        if (result_accepted) begin
            rec[0]   <= result_error ? 8'h45 : 8'h50;
            rec[1]   <= result_error ? {6'b0, result_pattern} : pass_count;
            rec[2]   <= addr_ext[15:8];
            rec[3]   <= addr_ext[7:0];
            rec[4]   <= result_expected[15:8];
            rec[5]   <= result_expected[7:0];
            rec[6]   <= result_actual[15:8];
            rec[7]   <= result_actual[7:0];
            last_idx <= result_error ? 3'd7 : 3'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            byte_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (result_accepted) begin
                        state    <= st_send;
                        byte_idx <= '0;
                    end
                end
                st_send: begin
                    if (tx_data_accepted) begin
                        if (byte_idx == last_idx) begin
                            state <= st_drain;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    // Last stop bit still on the line
                    if (tx_idle) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

/* sdp_ram.sv */
`timescale 1ns/10ps
`include "ram_selftest_settings.svh"

module sdp_ram (
    input  logic                        clk,
    input  logic                        wr_en,
    input  ram_selftest_pkg::rt_addr_t  wr_addr,
    input  ram_selftest_pkg::rt_data_t  wr_data,
    input  logic                        rd_en,
    input  ram_selftest_pkg::rt_addr_t  rd_addr,
    output ram_selftest_pkg::rt_data_t  rd_data
);

    (* ram_style = "block" *) ram_selftest_pkg::rt_data_t mem [`RT_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Output holds its last word while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Read-during-write to one address is undefined in block RAM
    a_no_rw_collision : assert property (
        @(posedge clk) !(wr_en && rd_en && (wr_addr == rd_addr))
    );

endmodule

/* sources.f */
+incdir+.
ram_selftest_pkg.sv
sdp_ram.sv
test_pattern_gen.sv
ram_test_ctrl.sv
report_formatter.sv
uart_tx.sv
ram_selftest_top.sv
tb_ram_selftest.sv

/* tb_ram_selftest.sv */
`timescale 1ns/10ps
`include "ram_selftest_settings.svh"

module tb_ram_selftest;

    localparam int pass_cycles   = `RT_NUM_PATTERNS * (2 * `RT_DEPTH + 8);
    localparam int record_cycles = 8 * 10 * `RT_BAUD_DIV;
    // Six runs with idle gaps and quiet checks, then doubled
    localparam int timeout_cycles = 2 * (6 * (pass_cycles + 2 * record_cycles + 128));

    logic                          clk;
    logic                          rst_n;
    logic                          start;
    logic                          tx;
    logic                          busy;
    ram_selftest_pkg::rt_pattern_t pattern_index;
    logic                          reading;

    logic [31:0]                   lcg_state = 32'd19;
    ram_selftest_pkg::rt_byte_t    rx_q[$];
    logic [7:0]                    model_count;

    ram_selftest_top i_ram_selftest_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .tx            (tx),
        .busy          (busy),
        .pattern_index (pattern_index),
        .reading       (reading)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Reference word for a pattern and address
    function automatic ram_selftest_pkg::rt_data_t expected_word(
        input ram_selftest_pkg::rt_pattern_t p, input ram_selftest_pkg::rt_addr_t a);
        ram_selftest_pkg::rt_data_t w;
        w = '0;
        w[`RT_ADDR_WIDTH-1:0] = a;
        case (p)
            ram_selftest_pkg::pat_address:     return w;
            ram_selftest_pkg::pat_inv_address: return ~w;
            ram_selftest_pkg::pat_checker:     return a[0] ? 16'hAAAA : 16'h5555;
            default:                           return a[0] ? 16'h5555 : 16'hAAAA;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input ram_selftest_pkg::rt_byte_t exp,
                              input ram_selftest_pkg::rt_byte_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input ram_selftest_pkg::rt_data_t exp,
                              input ram_selftest_pkg::rt_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input ram_selftest_pkg::rt_addr_t exp,
                              input ram_selftest_pkg::rt_addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_pattern(input string name, input ram_selftest_pkg::rt_pattern_t exp,
                                 input ram_selftest_pkg::rt_pattern_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // Serial decoder, samples each bit near its middle
    initial begin : uart_decoder
        ram_selftest_pkg::rt_byte_t data;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                repeat (`RT_BAUD_DIV / 2 - 1) @(negedge clk);
                if (tx !== 1'b0) begin
                    stop_on_error("UART start bit did not stay low");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (`RT_BAUD_DIV) @(negedge clk);
                    data[i] = tx;
                end
                repeat (`RT_BAUD_DIV) @(negedge clk);
                if (tx !== 1'b1) begin
                    stop_on_error("UART stop bit was low");
                end
                rx_q.push_back(data);
            end
        end
    end

    task automatic run_pass(input string name, input bit inject, input bit extra_start);
        int                            idle;
        int                            rises;
        bit                            injected;
        logic                          prev_reading;
        ram_selftest_pkg::rt_addr_t    fault_addr;
        ram_selftest_pkg::rt_data_t    mask;
        ram_selftest_pkg::rt_data_t    exp_word;
        ram_selftest_pkg::rt_pattern_t seen[$];
        ram_selftest_pkg::rt_byte_t    rec[$];
        int                            exp_len;

        idle       = next_rand() % 32;
        fault_addr = ram_selftest_pkg::rt_addr_t'(512 + (next_rand() % 512));
        mask       = next_rand();
        if (mask == '0) begin
            mask = 16'h0001;
        end
        // Back onto a rising edge first
        @(posedge clk);
        repeat (idle) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_bit({name, " busy rise"}, 1'b1, busy);
        // Second start while busy must be ignored
        if (extra_start) begin
            repeat (8) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
        end
        rises        = 0;
        injected     = 1'b0;
        prev_reading = 1'b0;
        while (busy) begin
            if (seen.size() == 0 || seen[$] != pattern_index) begin
                seen.push_back(pattern_index);
            end
            if (reading && !prev_reading) begin
                rises++;
                if (inject && !injected && pattern_index == ram_selftest_pkg::pat_address) begin
                    i_ram_selftest_top.i_ram.mem[fault_addr] =
                        i_ram_selftest_top.i_ram.mem[fault_addr] ^ mask;
                    injected = 1'b1;
                end
            end
            prev_reading = reading;
            @(negedge clk);
        end
        rec = rx_q;
        rx_q.delete();
        exp_len = inject ? 8 : 2;
        if (rec.size() != exp_len) begin
            stop_on_error($sformatf("Mismatch in %s record length: expected %0d, actual %0d",
                                    name, exp_len, rec.size()));
        end
        if (inject) begin
            if (!injected) begin
                stop_on_error("Fault could not be injected, reading never rose on pattern 0");
            end
            exp_word = expected_word(ram_selftest_pkg::pat_address, fault_addr);
            check_byte({name, " tag"}, 8'h45, rec[0]);
            check_byte({name, " pattern byte"}, 8'h00, rec[1]);
            check_pattern({name, " pattern"}, ram_selftest_pkg::pat_address,
                          ram_selftest_pkg::rt_pattern_t'(rec[1][1:0]));
            check_byte({name, " address high byte"},
                       ram_selftest_pkg::rt_byte_t'(fault_addr >> 8), rec[2]);
            check_addr({name, " address"}, fault_addr,
                       ram_selftest_pkg::rt_addr_t'({rec[2], rec[3]}));
            check_word({name, " expected word"}, exp_word, {rec[4], rec[5]});
            check_word({name, " actual word"}, exp_word ^ mask, {rec[6], rec[7]});
        end else begin
            model_count++;
            check_byte({name, " tag"}, 8'h50, rec[0]);
            check_byte({name, " pass count"}, model_count, rec[1]);
            if (seen.size() != `RT_NUM_PATTERNS || rises != `RT_NUM_PATTERNS) begin
                stop_on_error($sformatf(
                    "Mismatch in %s status: expected %0d patterns and reads, actual %0d and %0d",
                    name, `RT_NUM_PATTERNS, seen.size(), rises));
            end
            for (int i = 0; i < `RT_NUM_PATTERNS; i++) begin
                check_pattern({name, " pattern order"},
                              ram_selftest_pkg::rt_pattern_t'(i), seen[i]);
            end
        end
        if (extra_start) begin
            repeat (64) begin
                @(negedge clk);
                check_bit({name, " busy after ignored start"}, 1'b0, busy);
            end
            if (rx_q.size() != 0) begin
                stop_on_error("Extra record appeared after a start sent while busy");
            end
        end
    endtask

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        stop_on_error($sformatf("Watchdog expired after %0d cycles, the DUT hung",
                                timeout_cycles));
    end

    initial begin
        start       = 1'b0;
        rst_n       = 1'b0;
        model_count = 8'd0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("reset tx", 1'b1, tx);
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset reading", 1'b0, reading);
        check_pattern("reset pattern index", ram_selftest_pkg::pat_address, pattern_index);
        run_pass("clean pass 1", 1'b0, 1'b0);
        run_pass("clean pass 2", 1'b0, 1'b1);
        run_pass("clean pass 3", 1'b0, 1'b0);
        run_pass("clean pass 4", 1'b0, 1'b1);
        run_pass("fault pass", 1'b1, 1'b0);
        run_pass("clean pass after fault", 1'b0, 1'b0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* test_pattern_gen.sv */
`timescale 1ns/10ps
`include "ram_selftest_settings.svh"

module test_pattern_gen (
    input  ram_selftest_pkg::rt_pattern_t pattern,
    input  ram_selftest_pkg::rt_addr_t    addr,
    output ram_selftest_pkg::rt_data_t    word
);

    ram_selftest_pkg::rt_data_t addr_word;
    ram_selftest_pkg::rt_data_t checker_word;

    assign addr_word = `RT_DATA_WIDTH'(addr);

    // 0x5555 on even addresses, 0xAAAA on odd
    assign checker_word = addr[0] ? ~{(`RT_DATA_WIDTH/2){2'b01}}
                                  : {(`RT_DATA_WIDTH/2){2'b01}};

    always_comb begin
        case (pattern)
            ram_selftest_pkg::pat_address: begin
                word = addr_word;
            end
            ram_selftest_pkg::pat_inv_address: begin
                word = ~addr_word;
            end
            ram_selftest_pkg::pat_checker: begin
                word = checker_word;
            end
            default: begin
                word = ~checker_word;
            end
        endcase
    end

endmodule

/* uart_tx.sv */
`timescale 1ns/10ps
`include "ram_selftest_settings.svh"

module uart_tx (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ram_selftest_pkg::rt_byte_t tx_data,
    input  logic                       tx_data_ready,
    output logic                       tx_data_accepted,
    output logic                       tx_idle,
    output logic                       tx
);

    localparam int cnt_width = $clog2(`RT_BAUD_DIV);

    logic [cnt_width-1:0] baud_cnt;
    logic [3:0]           bit_cnt;
    logic [9:0]           shift;
    logic                 bit_end;

    assign tx_data_accepted = tx_idle && tx_data_ready;
    assign bit_end          = (baud_cnt == cnt_width'(`RT_BAUD_DIV - 1));
    assign tx               = shift[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_idle  <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shift    <= '1;
        end else if (tx_idle) begin
            if (tx_data_ready) begin
                // Stop, data LSB first, start
                shift    <= {1'b1, tx_data, 1'b0};
                tx_idle  <= 1'b0;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            if (bit_end) begin
                baud_cnt <= '0;
                shift    <= {1'b1, shift[9:1]};
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9) begin
                    tx_idle <= 1'b1;
                end
            end
        end
    end

    a_accept_starts_frame : assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_data_accepted |-> tx_data_ready ##1 (!tx_idle && !tx)
    );

endmodule
